/* verilog/tlb_pkg.sv */
`default_nettype none

package tlb_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [18:0] vpn2_t;
    typedef logic [19:0] pfn_t;
    typedef logic [7:0]  asid_t;
    typedef logic [2:0]  cattr_t;

    // command opcodes, OP_NOP is idle
    typedef enum logic [2:0] {
        OP_NOP   = 3'd0,
        OP_MTC0  = 3'd1,
        OP_MFC0  = 3'd2,
        OP_TLBWI = 3'd3,
        OP_TLBR  = 3'd4,
        OP_TLBP  = 3'd5
    } tlb_op_e;

    typedef enum logic [1:0] {
        REG_INDEX    = 2'd0,
        REG_ENTRYHI  = 2'd1,
        REG_ENTRYLO0 = 2'd2,
        REG_ENTRYLO1 = 2'd3
    } cp0_reg_e;

    // EntryHi fields
    localparam int EHI_VPN2_MSB = 31;
    localparam int EHI_VPN2_LSB = 13;
    localparam int EHI_ASID_MSB = 7;

    // EntryLo fields, bits above PFN read as zero
    localparam int ELO_PFN_MSB = 25;
    localparam int ELO_PFN_LSB = 6;
    localparam int ELO_C_MSB   = 5;
    localparam int ELO_C_LSB   = 3;
    localparam int ELO_D       = 2;
    localparam int ELO_V       = 1;
    localparam int ELO_G       = 0;

    // probe failure flag in Index
    localparam int INDEX_P = 31;

    localparam int PAGE_OFFSET_W = 12;

endpackage

`default_nettype wire

/* verilog/tlb_array.sv */
`timescale 1ns/10ps
`default_nettype none

module tlb_array #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic                             aclk,
    input  logic                             rst,
    // write port
    input  logic                             tlb_we,
    input  logic [$clog2(TLB_ENTRIES)-1:0]   w_index,
    input  tlb_pkg::vpn2_t                   w_vpn2,
    input  tlb_pkg::asid_t                   w_asid,
    input  logic                             w_g,
    input  tlb_pkg::pfn_t                    w_pfn0,
    input  tlb_pkg::cattr_t                  w_c0,
    input  logic                             w_d0,
    input  logic                             w_v0,
    input  tlb_pkg::pfn_t                    w_pfn1,
    input  tlb_pkg::cattr_t                  w_c1,
    input  logic                             w_d1,
    input  logic                             w_v1,
    // read port
    input  logic [$clog2(TLB_ENTRIES)-1:0]   r_index,
    output tlb_pkg::vpn2_t                   r_vpn2,
    output tlb_pkg::asid_t                   r_asid,
    output logic                             r_g,
    output tlb_pkg::pfn_t                    r_pfn0,
    output tlb_pkg::cattr_t                  r_c0,
    output logic                             r_d0,
    output logic                             r_v0,
    output tlb_pkg::pfn_t                    r_pfn1,
    output tlb_pkg::cattr_t                  r_c1,
    output logic                             r_d1,
    output logic                             r_v1,
    // probe port
    input  tlb_pkg::vpn2_t                   probe_vpn2,
    input  tlb_pkg::asid_t                   probe_asid,
    output logic                             probe_found,
    output logic [$clog2(TLB_ENTRIES)-1:0]   probe_index,
    // search port
    input  tlb_pkg::vpn2_t                   s_vpn2,
    input  logic                             s_odd,
    input  tlb_pkg::asid_t                   s_asid,
    output logic                             search_found,
    output tlb_pkg::pfn_t                    search_pfn,
    output tlb_pkg::cattr_t                  search_c,
    output logic                             search_d,
    output logic                             search_v
);
    import tlb_pkg::*;

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    vpn2_t  e_vpn2 [TLB_ENTRIES];
    asid_t  e_asid [TLB_ENTRIES];
    logic   e_g    [TLB_ENTRIES];
    pfn_t   e_pfn0 [TLB_ENTRIES];
    cattr_t e_c0   [TLB_ENTRIES];
    logic   e_d0   [TLB_ENTRIES];
    logic   e_v0   [TLB_ENTRIES];
    pfn_t   e_pfn1 [TLB_ENTRIES];
    cattr_t e_c1   [TLB_ENTRIES];
    logic   e_d1   [TLB_ENTRIES];
    logic   e_v1   [TLB_ENTRIES];

    logic [TLB_ENTRIES-1:0] s_hit;
    logic [TLB_ENTRIES-1:0] p_hit;

    // global entries ignore the asid
    function automatic logic entry_match(input vpn2_t e_vpn, input asid_t e_as,
                                         input logic e_glb, input vpn2_t vpn,
                                         input asid_t as);
        return (e_vpn == vpn) && (e_glb || (e_as == as));
    endfunction

    always_ff @(posedge aclk) begin
        if (rst) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                e_vpn2[i] <= '0;
                e_asid[i] <= '0;
                e_g[i]    <= 1'b0;
                e_pfn0[i] <= '0;
                e_c0[i]   <= '0;
                e_d0[i]   <= 1'b0;
                e_v0[i]   <= 1'b0;
                e_pfn1[i] <= '0;
                e_c1[i]   <= '0;
                e_d1[i]   <= 1'b0;
                e_v1[i]   <= 1'b0;
            end
        end else if (tlb_we) begin
            e_vpn2[w_index] <= w_vpn2;
            e_asid[w_index] <= w_asid;
            e_g[w_index]    <= w_g;
            e_pfn0[w_index] <= w_pfn0;
            e_c0[w_index]   <= w_c0;
            e_d0[w_index]   <= w_d0;
            e_v0[w_index]   <= w_v0;
            e_pfn1[w_index] <= w_pfn1;
            e_c1[w_index]   <= w_c1;
            e_d1[w_index]   <= w_d1;
            e_v1[w_index]   <= w_v1;
        end
    end

    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            s_hit[i] = entry_match(e_vpn2[i], e_asid[i], e_g[i], s_vpn2, s_asid);
            p_hit[i] = entry_match(e_vpn2[i], e_asid[i], e_g[i], probe_vpn2, probe_asid);
        end
    end

    // at most one hit, so OR-ing the selected page is a mux
    always_comb begin
        search_pfn = '0;
        search_c   = '0;
        search_d   = 1'b0;
        search_v   = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (s_hit[i]) begin
                search_pfn |= s_odd ? e_pfn1[i] : e_pfn0[i];
                search_c   |= s_odd ? e_c1[i] : e_c0[i];
                search_d   |= s_odd ? e_d1[i] : e_d0[i];
                search_v   |= s_odd ? e_v1[i] : e_v0[i];
            end
        end
    end

    assign search_found = |s_hit;

    always_comb begin
        probe_index = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (p_hit[i]) begin
                probe_index |= IDX_W'(i);
            end
        end
    end

    assign probe_found = |p_hit;

    assign r_vpn2 = e_vpn2[r_index];
    assign r_asid = e_asid[r_index];
    assign r_g    = e_g[r_index];
    assign r_pfn0 = e_pfn0[r_index];
    assign r_c0   = e_c0[r_index];
    assign r_d0   = e_d0[r_index];
    assign r_v0   = e_v0[r_index];
    assign r_pfn1 = e_pfn1[r_index];
    assign r_c1   = e_c1[r_index];
    assign r_d1   = e_d1[r_index];
    assign r_v1   = e_v1[r_index];

endmodule

`default_nettype wire

/* verilog/tlb_cp0_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module tlb_cp0_regs #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic                             aclk,
    input  logic                             rst,
    // command port
    input  tlb_pkg::tlb_op_e                 cmd_op,
    input  tlb_pkg::cp0_reg_e                cmd_reg,
    input  logic [31:0]                      cmd_wdata,
    output logic                             rsp_valid,
    output logic [31:0]                      rsp_data,
    // array write port
    output logic                             tlb_we,
    output logic [$clog2(TLB_ENTRIES)-1:0]   w_index,
    output tlb_pkg::vpn2_t                   w_vpn2,
    output tlb_pkg::asid_t                   w_asid,
    output logic                             w_g,
    output tlb_pkg::pfn_t                    w_pfn0,
    output tlb_pkg::cattr_t                  w_c0,
    output logic                             w_d0,
    output logic                             w_v0,
    output tlb_pkg::pfn_t                    w_pfn1,
    output tlb_pkg::cattr_t                  w_c1,
    output logic                             w_d1,
    output logic                             w_v1,
    // array read port
    output logic [$clog2(TLB_ENTRIES)-1:0]   r_index,
    input  tlb_pkg::vpn2_t                   r_vpn2,
    input  tlb_pkg::asid_t                   r_asid,
    input  logic                             r_g,
    input  tlb_pkg::pfn_t                    r_pfn0,
    input  tlb_pkg::cattr_t                  r_c0,
    input  logic                             r_d0,
    input  logic                             r_v0,
    input  tlb_pkg::pfn_t                    r_pfn1,
    input  tlb_pkg::cattr_t                  r_c1,
    input  logic                             r_d1,
    input  logic                             r_v1,
    // probe
    output tlb_pkg::vpn2_t                   probe_vpn2,
    output tlb_pkg::asid_t                   probe_asid,
    input  logic                             probe_found,
    input  logic [$clog2(TLB_ENTRIES)-1:0]   probe_index,
    output tlb_pkg::asid_t                   cur_asid
);
    import tlb_pkg::*;

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    logic                 index_p;
    logic [IDX_W-1:0]     index_val;
    vpn2_t                ehi_vpn2;
    asid_t                ehi_asid;
    logic [ELO_PFN_MSB:0] lo0;
    logic [ELO_PFN_MSB:0] lo1;
    logic [31:0]          reg_rdata;

    always_ff @(posedge aclk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
            index_p   <= 1'b0;
            index_val <= '0;
            ehi_vpn2  <= '0;
            ehi_asid  <= '0;
            lo0       <= '0;
            lo1       <= '0;
        end else begin
            rsp_valid <= (cmd_op == OP_MFC0);
            case (cmd_op)
                OP_MTC0: begin
                    case (cmd_reg)
                        REG_INDEX: begin
                            index_val <= cmd_wdata[IDX_W-1:0];
                            index_p   <= 1'b0;
                        end
                        REG_ENTRYHI: begin
                            ehi_vpn2 <= cmd_wdata[EHI_VPN2_MSB:EHI_VPN2_LSB];
                            ehi_asid <= cmd_wdata[EHI_ASID_MSB:0];
                        end
                        REG_ENTRYLO0: lo0 <= cmd_wdata[ELO_PFN_MSB:0];
                        REG_ENTRYLO1: lo1 <= cmd_wdata[ELO_PFN_MSB:0];
                        default: ;
                    endcase
                end
                OP_TLBR: begin
                    ehi_vpn2 <= r_vpn2;
                    ehi_asid <= r_asid;
                    lo0      <= {r_pfn0, r_c0, r_d0, r_v0, r_g};
                    lo1      <= {r_pfn1, r_c1, r_d1, r_v1, r_g};
                end
                OP_TLBP: begin
                    // index bits kept on a miss
                    if (probe_found) begin
                        index_val <= probe_index;
                    end
                    index_p <= ~probe_found;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        reg_rdata = '0;
        case (cmd_reg)
            REG_INDEX: begin
                reg_rdata[INDEX_P]     = index_p;
                reg_rdata[IDX_W-1:0]   = index_val;
            end
            REG_ENTRYHI: begin
                reg_rdata[EHI_VPN2_MSB:EHI_VPN2_LSB] = ehi_vpn2;
                reg_rdata[EHI_ASID_MSB:0]            = ehi_asid;
            end
            REG_ENTRYLO0: reg_rdata[ELO_PFN_MSB:0] = lo0;
            REG_ENTRYLO1: reg_rdata[ELO_PFN_MSB:0] = lo1;
            default: ;
        endcase
    end

    // value before the command edge
    always_ff @(posedge aclk) begin
        if (cmd_op == OP_MFC0) begin
            rsp_data <= reg_rdata;
        end
    end

    assign tlb_we  = (cmd_op == OP_TLBWI);
    assign w_index = index_val;
    assign w_vpn2  = ehi_vpn2;
    assign w_asid  = ehi_asid;
    assign w_g     = lo0[ELO_G] & lo1[ELO_G];
    assign w_pfn0  = lo0[ELO_PFN_MSB:ELO_PFN_LSB];
    assign w_c0    = lo0[ELO_C_MSB:ELO_C_LSB];
    assign w_d0    = lo0[ELO_D];
    assign w_v0    = lo0[ELO_V];
    assign w_pfn1  = lo1[ELO_PFN_MSB:ELO_PFN_LSB];
    assign w_c1    = lo1[ELO_C_MSB:ELO_C_LSB];
    assign w_d1    = lo1[ELO_D];
    assign w_v1    = lo1[ELO_V];

    assign r_index    = index_val;
    assign probe_vpn2 = ehi_vpn2;
    assign probe_asid = ehi_asid;
    assign cur_asid   = ehi_asid;

endmodule

`default_nettype wire

/* verilog/tlb_translate.sv */
`timescale 1ns/10ps
`default_nettype none

module tlb_translate (
    input  logic             aclk,
    input  logic             rst,
    // request side
    input  logic             va_valid,
    output logic             va_ready,
    input  tlb_pkg::vaddr_t  va,
    input  tlb_pkg::asid_t   cur_asid,
    // search port
    output tlb_pkg::vpn2_t   s_vpn2,
    output logic             s_odd,
    output tlb_pkg::asid_t   s_asid,
    input  logic             search_found,
    input  tlb_pkg::pfn_t    search_pfn,
    input  logic             search_v,
    // result side
    output logic             pa_valid,
    input  logic             pa_ready,
    output tlb_pkg::paddr_t  pa,
    output logic             pa_miss,
    output logic             pa_invalid
);
    import tlb_pkg::*;

    logic   s1_valid;
    vaddr_t s1_va;
    logic   s1_take;
    paddr_t s1_pa;
    logic   s2_valid;
    logic   s2_ready;

    // stage 2 free or draining this cycle
    assign s2_ready = !s2_valid || pa_ready;
    assign va_ready = !s1_valid || s2_ready;
    assign s1_take  = va_valid && va_ready;

    assign s_vpn2 = s1_va[31:PAGE_OFFSET_W+1];
    assign s_odd  = s1_va[PAGE_OFFSET_W];
    assign s_asid = cur_asid;

    // pa still formed for invalid pages, zero on miss
    assign s1_pa = search_found ? {search_pfn, s1_va[PAGE_OFFSET_W-1:0]} : '0;

    always_ff @(posedge aclk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else if (va_ready) begin
            s1_valid <= va_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (s1_take) begin
            s1_va <= va;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else if (s2_ready) begin
            s2_valid <= s1_valid;
        end
    end

    // held while pa_ready is low
    always_ff @(posedge aclk) begin
        if (s2_ready && s1_valid) begin
            pa         <= s1_pa;
            pa_miss    <= ~search_found;
            pa_invalid <= search_found & ~search_v;
        end
    end

    assign pa_valid = s2_valid;

endmodule

`default_nettype wire

/* verilog/tlb_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tlb_top #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic               aclk,
    input  logic               rst,
    // command port
    input  tlb_pkg::tlb_op_e   cmd_op,
    input  tlb_pkg::cp0_reg_e  cmd_reg,
    input  logic [31:0]        cmd_wdata,
    output logic               rsp_valid,
    output logic [31:0]        rsp_data,
    // translation port
    input  logic               va_valid,
    input  tlb_pkg::vaddr_t    va,
    output logic               va_ready,
    output logic               pa_valid,
    output tlb_pkg::paddr_t    pa,
    output logic               pa_miss,
    output logic               pa_invalid,
    input  logic               pa_ready
);
    import tlb_pkg::*;

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    // register block to array
    logic             tlb_we;
    logic [IDX_W-1:0] w_index;
    vpn2_t            w_vpn2;
    asid_t            w_asid;
    logic             w_g;
    pfn_t             w_pfn0;
    cattr_t           w_c0;
    logic             w_d0;
    logic             w_v0;
    pfn_t             w_pfn1;
    cattr_t           w_c1;
    logic             w_d1;
    logic             w_v1;
    logic [IDX_W-1:0] r_index;
    vpn2_t            r_vpn2;
    asid_t            r_asid;
    logic             r_g;
    pfn_t             r_pfn0;
    cattr_t           r_c0;
    logic             r_d0;
    logic             r_v0;
    pfn_t             r_pfn1;
    cattr_t           r_c1;
    logic             r_d1;
    logic             r_v1;
    vpn2_t            probe_vpn2;
    asid_t            probe_asid;
    logic             probe_found;
    logic [IDX_W-1:0] probe_index;

    // current asid from EntryHi drives the search
    asid_t            cur_asid;
    vpn2_t            s_vpn2;
    logic             s_odd;
    asid_t            s_asid;
    logic             search_found;
    pfn_t             search_pfn;
    logic             search_v;

    tlb_cp0_regs #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_cp0_regs (
        .*
    );

    // cache attribute and dirty bit unused by translation
    tlb_array #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_array (
        .search_c (),
        .search_d (),
        .*
    );

    tlb_translate u_translate (
        .*
    );

endmodule

`default_nettype wire

/* include/tlb_tb_model.svh */
`ifndef TLB_TB_MODEL_SVH
`define TLB_TB_MODEL_SVH

// shadow copies of the cp0 registers
logic [3:0]  m_index;
logic        m_p;
vpn2_t       m_ehi_vpn2;
asid_t       m_ehi_asid;
logic [25:0] m_lo0;
logic [25:0] m_lo1;

// entry contents, bit 0 of each half holds the global bit
vpn2_t       ent_vpn2 [16];
asid_t       ent_asid [16];
logic [25:0] ent_lo0  [16];
logic [25:0] ent_lo1  [16];

task automatic clear_model();
    m_index    = '0;
    m_p        = 1'b0;
    m_ehi_vpn2 = '0;
    m_ehi_asid = '0;
    m_lo0      = '0;
    m_lo1      = '0;
    for (int i = 0; i < 16; i++) begin
        ent_vpn2[i] = '0;
        ent_asid[i] = '0;
        ent_lo0[i]  = '0;
        ent_lo1[i]  = '0;
    end
endtask

function automatic logic [31:0] expected_reg(input cp0_reg_e sel);
    case (sel)
        REG_INDEX:    return {m_p, 27'd0, m_index};
        REG_ENTRYHI:  return {m_ehi_vpn2, 5'd0, m_ehi_asid};
        REG_ENTRYLO0: return {6'd0, m_lo0};
        default:      return {6'd0, m_lo1};
    endcase
endfunction

// entry number of the match, -1 when none
function automatic int expected_probe(input vpn2_t vpn2, input asid_t asid);
    for (int i = 0; i < 16; i++) begin
        if ((ent_vpn2[i] == vpn2) && (ent_lo0[i][0] || (ent_asid[i] == asid))) begin
            return i;
        end
    end
    return -1;
endfunction

function automatic paddr_t expected_translate(input vaddr_t addr, input asid_t asid,
                                              output logic miss, output logic inv);
    int          hit;
    logic [25:0] lo;
    hit = expected_probe(addr[31:13], asid);
    if (hit < 0) begin
        miss = 1'b1;
        inv  = 1'b0;
        return '0;
    end
    // bit 12 picks the odd page
    lo   = addr[12] ? ent_lo1[hit] : ent_lo0[hit];
    miss = 1'b0;
    inv  = ~lo[1];
    return {lo[25:6], addr[11:0]};
endfunction

task automatic model_mtc0(input cp0_reg_e sel, input logic [31:0] data);
    case (sel)
        REG_INDEX: begin
            m_index = data[3:0];
            m_p     = 1'b0;
        end
        REG_ENTRYHI: begin
            m_ehi_vpn2 = data[31:13];
            m_ehi_asid = data[7:0];
        end
        REG_ENTRYLO0: m_lo0 = data[25:0];
        default:      m_lo1 = data[25:0];
    endcase
endtask

task automatic model_tlb(input tlb_op_e op);
    int   hit;
    logic g;
    g = m_lo0[0] & m_lo1[0];
    case (op)
        OP_TLBWI: begin
            ent_vpn2[m_index] = m_ehi_vpn2;
            ent_asid[m_index] = m_ehi_asid;
            ent_lo0[m_index]  = {m_lo0[25:1], g};
            ent_lo1[m_index]  = {m_lo1[25:1], g};
        end
        OP_TLBR: begin
            m_ehi_vpn2 = ent_vpn2[m_index];
            m_ehi_asid = ent_asid[m_index];
            m_lo0      = ent_lo0[m_index];
            m_lo1      = ent_lo1[m_index];
        end
        OP_TLBP: begin
            hit = expected_probe(m_ehi_vpn2, m_ehi_asid);
            if (hit >= 0) begin
                m_index = 4'(hit);
                m_p     = 1'b0;
            end else begin
                m_p = 1'b1;
            end
        end
        default: ;
    endcase
endtask

`endif

/* testbench/tlb_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module tlb_tb;
    import tlb_pkg::*;

    localparam int SEED        = 21492;
    localparam int HALF_PERIOD = 20;
    localparam int DRIVE_DELAY = 2;
    localparam int CYCLE_LIMIT = 2000;
    localparam int IDLE_LIMIT  = 50;
    localparam int N_RANDOM_VA = 100;

    logic        aclk = 1'b0;
    logic        rst;
    tlb_op_e     cmd_op;
    cp0_reg_e    cmd_reg;
    logic [31:0] cmd_wdata;
    logic        rsp_valid;
    logic [31:0] rsp_data;
    logic        va_valid;
    vaddr_t      va;
    logic        va_ready;
    logic        pa_valid;
    paddr_t      pa;
    logic        pa_miss;
    logic        pa_invalid;
    logic        pa_ready = 1'b1;

    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    logic        random_ready = 1'b0;
    logic        held = 1'b0;
    logic [31:0] exp_rsp_q [$];
    paddr_t      exp_pa_q [$];
    logic        exp_miss_q [$];
    logic        exp_inv_q [$];

    `include "tlb_tb_model.svh"

    tlb_top uut (.*);

    always #HALF_PERIOD aclk = ~aclk;

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout, the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    // stall the result side during the random stream
    always @(posedge aclk) begin
        #DRIVE_DELAY;
        pa_ready = random_ready ? 1'($urandom()) : 1'b1;
    end

    task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_pa(input string name, input paddr_t exp, input paddr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    // outputs sampled mid-cycle
    always @(negedge aclk) begin
        if (!rst) begin
            if (rsp_valid) begin
                if (exp_rsp_q.size() == 0) begin
                    errors++;
                    $display("rsp_valid pulsed at %0t with no mfc0 pending", $time);
                end else begin
                    check_reg("rsp_data", exp_rsp_q.pop_front(), rsp_data);
                end
            end
            // a stalled result stays valid
            if (held) begin
                check_flag("pa_valid", 1'b1, pa_valid);
            end
            held = pa_valid && !pa_ready;
            if (pa_valid) begin
                if (exp_pa_q.size() == 0) begin
                    errors++;
                    $display("translation result at %0t with no request pending", $time);
                end else begin
                    check_pa("pa", exp_pa_q[0], pa);
                    check_flag("pa_miss", exp_miss_q[0], pa_miss);
                    check_flag("pa_invalid", exp_inv_q[0], pa_invalid);
                    if (pa_ready) begin
                        exp_pa_q.delete(0);
                        exp_miss_q.delete(0);
                        exp_inv_q.delete(0);
                    end
                end
            end
        end
    end

    task automatic issue_cmd(input tlb_op_e op, input cp0_reg_e sel, input logic [31:0] data);
        cmd_op    = op;
        cmd_reg   = sel;
        cmd_wdata = data;
        @(posedge aclk);
        #DRIVE_DELAY;
        cmd_op = OP_NOP;
    endtask

    task automatic write_reg(input cp0_reg_e sel, input logic [31:0] data);
        model_mtc0(sel, data);
        issue_cmd(OP_MTC0, sel, data);
    endtask

    task automatic read_reg(input cp0_reg_e sel);
        exp_rsp_q.push_back(expected_reg(sel));
        issue_cmd(OP_MFC0, sel, 32'd0);
    endtask

    task automatic tlb_cmd(input tlb_op_e op);
        model_tlb(op);
        issue_cmd(op, REG_INDEX, 32'd0);
    endtask

    task automatic send_va(input vaddr_t addr);
        paddr_t p;
        logic   miss;
        logic   inv;
        p        = expected_translate(addr, m_ehi_asid, miss, inv);
        va_valid = 1'b1;
        va       = addr;
        @(negedge aclk);
        while (!va_ready) begin
            @(negedge aclk);
        end
        exp_pa_q.push_back(p);
        exp_miss_q.push_back(miss);
        exp_inv_q.push_back(inv);
        @(posedge aclk);
        #DRIVE_DELAY;
        va_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int n = 0;
        while ((exp_rsp_q.size() != 0 || exp_pa_q.size() != 0) && n < IDLE_LIMIT) begin
            @(posedge aclk);
            #DRIVE_DELAY;
            n++;
        end
        if (n >= IDLE_LIMIT) begin
            errors++;
            $display("%0d register and %0d translation results never arrived",
                     exp_rsp_q.size(), exp_pa_q.size());
            exp_rsp_q.delete();
            exp_pa_q.delete();
            exp_miss_q.delete();
            exp_inv_q.delete();
        end
    endtask

    task automatic end_test(input string name);
        wait_idle();
        $display("test %s finished, %0d errors so far", name, errors);
    endtask

    task automatic test_reg_moves();
        read_reg(REG_INDEX);
        read_reg(REG_ENTRYHI);
        read_reg(REG_ENTRYLO0);
        read_reg(REG_ENTRYLO1);
        for (int k = 0; k < 3; k++) begin
            write_reg(REG_INDEX, $urandom());
            read_reg(REG_INDEX);
            write_reg(REG_ENTRYHI, $urandom());
            read_reg(REG_ENTRYHI);
            write_reg(REG_ENTRYLO0, $urandom());
            read_reg(REG_ENTRYLO0);
            write_reg(REG_ENTRYLO1, $urandom());
            read_reg(REG_ENTRYLO1);
        end
        end_test("register moves");
    endtask

    task automatic test_write_read();
        logic [31:0] hi;
        logic [31:0] lo0;
        logic [31:0] lo1;
        for (int i = 0; i < 16; i++) begin
            // unique vpn2 per entry from its low nibble
            hi  = {1'b0, 14'($urandom()), 4'(i), 5'($urandom()), 8'($urandom())};
            lo0 = $urandom();
            lo1 = $urandom();
            case (i % 4)
                0: begin
                    lo0[1:0] = 2'b10;
                    lo1[1:0] = 2'b10;
                end
                1: begin
                    lo0[0] = 1'b1;
                    lo1[0] = 1'b1;
                end
                2: begin
                    lo0[0] = 1'b1;
                    lo1[0] = 1'b0;
                end
                default: begin
                    lo0[1:0] = 2'b00;
                    lo1[1]   = 1'b1;
                end
            endcase
            write_reg(REG_INDEX, 32'(i));
            write_reg(REG_ENTRYHI, hi);
            write_reg(REG_ENTRYLO0, lo0);
            write_reg(REG_ENTRYLO1, lo1);
            tlb_cmd(OP_TLBWI);
        end
        for (int i = 0; i < 16; i++) begin
            write_reg(REG_INDEX, 32'(i));
            tlb_cmd(OP_TLBR);
            read_reg(REG_ENTRYHI);
            read_reg(REG_ENTRYLO0);
            read_reg(REG_ENTRYLO1);
        end
        end_test("tlbwi and tlbr");
    endtask

    task automatic test_probe();
        write_reg(REG_INDEX, 32'd7);
        write_reg(REG_ENTRYHI, {ent_vpn2[3], 5'd0, ent_asid[3]});
        tlb_cmd(OP_TLBP);
        read_reg(REG_INDEX);
        // global entry under a foreign asid
        write_reg(REG_ENTRYHI, {ent_vpn2[5], 5'd0, ent_asid[5] ^ 8'h5a});
        tlb_cmd(OP_TLBP);
        read_reg(REG_INDEX);
        write_reg(REG_ENTRYHI, {ent_vpn2[4], 5'd0, ent_asid[4] ^ 8'h5a});
        tlb_cmd(OP_TLBP);
        read_reg(REG_INDEX);
        // P from the miss above cleared by the move
        write_reg(REG_INDEX, 32'd9);
        read_reg(REG_INDEX);
        write_reg(REG_ENTRYHI, {1'b1, 18'($urandom()), 5'd0, 8'($urandom())});
        tlb_cmd(OP_TLBP);
        read_reg(REG_INDEX);
        end_test("tlbp");
    endtask

    task automatic test_translate();
        for (int i = 0; i < 4; i++) begin
            wait_idle();
            write_reg(REG_ENTRYHI, {19'd0, 5'd0, ent_asid[i]});
            send_va({ent_vpn2[i], 1'b0, 12'($urandom())});
            send_va({ent_vpn2[i], 1'b1, 12'($urandom())});
            wait_idle();
            write_reg(REG_ENTRYHI, {19'd0, 5'd0, ~ent_asid[i]});
            send_va({ent_vpn2[i], 1'($urandom()), 12'($urandom())});
        end
        send_va({1'b1, 18'($urandom()), 13'($urandom())});
        end_test("translation rules");
    endtask

    task automatic test_random_stream();
        vaddr_t a;
        int     pick;
        wait_idle();
        write_reg(REG_ENTRYHI, {19'd0, 5'd0, ent_asid[0]});
        random_ready = 1'b1;
        for (int k = 0; k < N_RANDOM_VA; k++) begin
            pick = $urandom_range(19, 0);
            if (pick < 16) begin
                a = {ent_vpn2[pick], 13'($urandom())};
            end else begin
                a = $urandom();
            end
            send_va(a);
        end
        end_test("random stream with back-pressure");
        random_ready = 1'b0;
    endtask

    initial begin
        void'($urandom(SEED));
        rst       = 1'b1;
        cmd_op    = OP_NOP;
        cmd_reg   = REG_INDEX;
        cmd_wdata = '0;
        va_valid  = 1'b0;
        va        = '0;
        clear_model();
        repeat (2) @(posedge aclk);
        #DRIVE_DELAY;
        rst = 1'b0;
        check_flag("va_ready", 1'b1, va_ready);
        check_flag("pa_valid", 1'b0, pa_valid);
        check_flag("rsp_valid", 1'b0, rsp_valid);
        test_reg_moves();
        test_write_read();
        test_probe();
        test_translate();
        test_random_stream();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
verilog/tlb_pkg.sv
verilog/tlb_array.sv
verilog/tlb_cp0_regs.sv
verilog/tlb_translate.sv
verilog/tlb_top.sv
testbench/tlb_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module tlb_tb -o sim_tlb
out=$(./obj_dir/sim_tlb)
echo "$out"

if echo "$out" | grep -q "^Simulation passed$"; then
    exit 0
fi
exit 1
